// File: source/decode_pkg.sv
package decode_pkg;

    // Base opcodes of the RV32I subset handled here
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        imm_i        = 3'b000,
        imm_s        = 3'b001,
        imm_b        = 3'b010,
        imm_u        = 3'b011,
        imm_j        = 3'b100,
        imm_i_zext_a = 3'b101, // Halfword loads
        imm_i_zext_b = 3'b110  // Doubleword load
    } imm_src_t;

    typedef enum logic [2:0] {
        br_eq   = 3'b000,
        br_ne   = 3'b001,
        br_none = 3'b010,
        br_jump = 3'b011,
        br_lt   = 3'b100,
        br_ge   = 3'b101,
        br_geu  = 3'b110,
        br_ltu  = 3'b111
    } branch_src_t;

    typedef struct packed {
        logic [1:0]  alu_op;      // 00 add, 01 sub, 10 from func fields
        imm_src_t    imm_src;
        branch_src_t branch_src;
        logic        mem_write;
        logic [1:0]  alu_mux_src; // {op1 is pc, op2 is imm}
        logic [1:0]  wb_src;
        logic        reg_write;
        logic        branch_valid;
        logic        is_immediate;
        logic        illegal;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        alu_op_t     alu_ctrl;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } decoded_t;

endpackage

// File: source/fourphase_slot.sv
`timescale 1ns/1ps

module fourphase_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     up_req,
    output logic     up_ack,
    input  payload_t up_data,
    output logic     dn_req,
    input  logic     dn_ack,
    output payload_t dn_data
);

    typedef enum logic [1:0] {
        dn_idle,  // Slot empty
        dn_offer, // Full, req raised downstream
        dn_drain  // Waiting for dn_ack to drop
    } dn_state_t;

    dn_state_t dn_state;
    payload_t  data_q;
    logic      capture;

    // New item only when empty and the previous upstream cycle has closed
    assign capture = up_req && !up_ack && (dn_state == dn_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            up_ack <= 1'b0;
        end else if (capture) begin
            up_ack <= 1'b1;
        end else if (!up_req) begin
            up_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dn_state <= dn_idle;
        end else begin
            case (dn_state)
                dn_idle:  if (capture) dn_state <= dn_offer;
                dn_offer: if (dn_ack) dn_state <= dn_drain;
                dn_drain: if (!dn_ack) dn_state <= dn_idle;
                default:  dn_state <= dn_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_q <= up_data; // Held until the slot is empty again
    end

    assign dn_req  = (dn_state == dn_offer);
    assign dn_data = data_q;

endmodule

// File: source/main_decoder.sv
`timescale 1ns/1ps

module main_decoder import decode_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] func3,
    output ctrl_t      ctrl
);

    logic op1_src; // Operand 1 from pc
    logic op2_src; // Operand 2 from immediate

    always_comb begin
        case (opcode)
            op_r: begin
                op1_src           = 1'b0;
                op2_src           = 1'b0;
                ctrl.wb_src       = 2'b01;
                ctrl.reg_write    = 1'b1;
                ctrl.mem_write    = 1'b0;
                ctrl.alu_op       = 2'b10;
                ctrl.imm_src      = imm_i;
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            op_load: begin
                op1_src        = 1'b0;
                op2_src        = 1'b1;
                ctrl.wb_src    = 2'b11; // Memory data
                ctrl.reg_write = 1'b1;
                ctrl.mem_write = 1'b0;
                ctrl.alu_op    = 2'b00;
                case (func3)
                    3'h3:    ctrl.imm_src = imm_i_zext_b;
                    3'h5:    ctrl.imm_src = imm_i_zext_a;
                    3'h1:    ctrl.imm_src = imm_i_zext_a;
                    default: ctrl.imm_src = imm_i;
                endcase
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            op_imm: begin
                op1_src           = 1'b0;
                op2_src           = 1'b1;
                ctrl.wb_src       = 2'b01;
                ctrl.reg_write    = 1'b1;
                ctrl.mem_write    = 1'b0;
                ctrl.alu_op       = 2'b10;
                ctrl.imm_src      = imm_i;
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b1; // Keeps sub out of addi
                ctrl.illegal      = 1'b0;
            end
            op_store: begin
                op1_src           = 1'b0;
                op2_src           = 1'b1;
                ctrl.wb_src       = 2'b00;
                ctrl.reg_write    = 1'b0;
                ctrl.mem_write    = 1'b1;
                ctrl.alu_op       = 2'b00;
                ctrl.imm_src      = imm_s;
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            op_branch: begin
                op1_src        = 1'b1; // Target is pc relative
                op2_src        = 1'b1;
                ctrl.wb_src    = 2'b00;
                ctrl.reg_write = 1'b0;
                ctrl.mem_write = 1'b0;
                ctrl.alu_op    = 2'b01; // Compare by subtraction
                ctrl.imm_src   = imm_b;
                case (func3)
                    3'h0:    ctrl.branch_src = br_eq;
                    3'h1:    ctrl.branch_src = br_ne;
                    3'h4:    ctrl.branch_src = br_lt;
                    3'h5:    ctrl.branch_src = br_ge;
                    3'h6:    ctrl.branch_src = br_ltu;
                    3'h7:    ctrl.branch_src = br_geu;
                    default: ctrl.branch_src = br_none;
                endcase
                ctrl.branch_valid = 1'b1;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            op_jal, op_jalr: begin
                op1_src           = (opcode == op_jal); // jalr adds to rs1
                op2_src           = 1'b1;
                ctrl.wb_src       = 2'b00;
                ctrl.reg_write    = 1'b1;
                ctrl.mem_write    = 1'b0;
                ctrl.alu_op       = 2'b00;
                ctrl.imm_src      = imm_j;
                ctrl.branch_src   = br_jump;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            op_lui, op_auipc: begin
                op1_src           = (opcode == op_auipc);
                op2_src           = (opcode == op_auipc);
                ctrl.wb_src       = (opcode == op_lui) ? 2'b10 : 2'b01;
                ctrl.reg_write    = 1'b1;
                ctrl.mem_write    = 1'b0;
                ctrl.alu_op       = 2'b00;
                ctrl.imm_src      = imm_u;
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b0;
            end
            default: begin
                op1_src           = 1'b0;
                op2_src           = 1'b0;
                ctrl.wb_src       = 2'b00;
                ctrl.reg_write    = 1'b0;
                ctrl.mem_write    = 1'b0;
                ctrl.alu_op       = 2'b01;
                ctrl.imm_src      = imm_i;
                ctrl.branch_src   = br_none;
                ctrl.branch_valid = 1'b0;
                ctrl.is_immediate = 1'b0;
                ctrl.illegal      = 1'b1; // Also fence and system
            end
        endcase

        ctrl.alu_mux_src = {op1_src, op2_src};
    end

endmodule

// File: source/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import decode_pkg::*; (
    input  logic [2:0] func3,
    input  logic       func7_5,
    input  logic       op_5,
    output alu_op_t    alu_ctrl
);

    always_comb begin
        case (func3)
            3'b000: begin
                // Immediate form has no subi, func7 bits are part of imm
                if (op_5 && func7_5) begin
                    alu_ctrl = alu_sub;
                end else begin
                    alu_ctrl = alu_add;
                end
            end
            3'b001: alu_ctrl = alu_sll;
            3'b010: alu_ctrl = alu_slt;
            3'b011: alu_ctrl = alu_sltu;
            3'b100: alu_ctrl = alu_xor;
            3'b101: begin
                if (func7_5) begin
                    alu_ctrl = alu_sra; // srai shares the encoding
                end else begin
                    alu_ctrl = alu_srl;
                end
            end
            3'b110: alu_ctrl = alu_or;
            default: alu_ctrl = alu_and;
        endcase
    end

endmodule

// File: source/decode_combine.sv
`timescale 1ns/1ps

module decode_combine import decode_pkg::*; (
    input  fetch_t   fetch,
    input  ctrl_t    ctrl,
    input  alu_op_t  alu_r,
    output decoded_t dec
);

    logic [31:0] instr;
    logic        bad_branch;

    assign instr = fetch.instr;

    // func3 010 and 011 have no branch condition
    assign bad_branch = ctrl.branch_valid && (ctrl.branch_src == br_none);

    always_comb begin
        dec.pc           = fetch.pc;
        dec.ctrl         = ctrl;
        dec.ctrl.illegal = ctrl.illegal | bad_branch;

        case (ctrl.alu_op)
            2'b00:   dec.alu_ctrl = alu_add;
            2'b01:   dec.alu_ctrl = alu_sub;
            2'b10:   dec.alu_ctrl = alu_r;
            default: dec.alu_ctrl = alu_add;
        endcase

        case (ctrl.imm_src)
            imm_i: dec.imm = {{20{instr[31]}}, instr[31:20]};
            imm_s: dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b: begin
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            imm_u: dec.imm = {instr[31:12], 12'b0};
            imm_j: begin
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            imm_i_zext_a, imm_i_zext_b: dec.imm = {20'b0, instr[31:20]};
            default: dec.imm = 32'b0;
        endcase

        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
    end

endmodule

// File: source/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import decode_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     fetch_req,
    output logic     fetch_ack,
    input  fetch_t   fetch,
    output logic     dec_req,
    input  logic     dec_ack,
    output decoded_t dec
);

    fetch_t   held;     // Instruction sitting in the input slot
    logic     mid_req;
    logic     mid_ack;
    ctrl_t    ctrl;
    alu_op_t  alu_r;
    decoded_t dec_next;

    fourphase_slot #(.payload_t(fetch_t)) u_in_slot (
        .clk     (clk),
        .reset   (reset),
        .up_req  (fetch_req),
        .up_ack  (fetch_ack),
        .up_data (fetch),
        .dn_req  (mid_req),
        .dn_ack  (mid_ack),
        .dn_data (held)
    );

    main_decoder u_main_decoder (
        .opcode (held.instr[6:0]),
        .func3  (held.instr[14:12]),
        .ctrl   (ctrl)
    );

    alu_decoder u_alu_decoder (
        .func3    (held.instr[14:12]),
        .func7_5  (held.instr[30]),
        .op_5     (held.instr[5]),
        .alu_ctrl (alu_r)
    );

    decode_combine u_decode_combine (
        .fetch (held),
        .ctrl  (ctrl),
        .alu_r (alu_r),
        .dec   (dec_next)
    );

    fourphase_slot #(.payload_t(decoded_t)) u_out_slot (
        .clk     (clk),
        .reset   (reset),
        .up_req  (mid_req),
        .up_ack  (mid_ack),
        .up_data (dec_next),
        .dn_req  (dec_req),
        .dn_ack  (dec_ack),
        .dn_data (dec)
    );

endmodule

// File: dv/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     fetch_ack,
    input  logic     dec_req,
    input  decoded_t dec,
    input  decoded_t exp_tab [0:31],
    input  int       n_rows,
    output int       n_seen,
    output int       n_err
);

    logic req_q;
    logic reset_q;

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            n_err++;
        end
    endtask

    initial begin
        n_seen = 0;
        n_err  = 0;
    end

    always @(posedge clk) begin
        req_q   <= reset ? 1'b0 : dec_req;
        reset_q <= reset;
        if (reset_q && !reset) begin // First edge after reset release
            compare_field("fetch_ack", 32'd0, {31'd0, fetch_ack});
            compare_field("dec_req", 32'd0, {31'd0, dec_req});
        end
        if (!reset && dec_req && !req_q) begin
            if (n_seen >= n_rows) begin
                $display("extra decoded packet at %0t with pc %h", $time, dec.pc);
                n_err++;
            end else begin
                compare_field("dec.pc", exp_tab[n_seen].pc, dec.pc);
                compare_field("dec.ctrl", 32'(exp_tab[n_seen].ctrl), 32'(dec.ctrl));
                compare_field("dec.alu_ctrl", 32'(exp_tab[n_seen].alu_ctrl),
                              32'(dec.alu_ctrl));
                compare_field("dec.imm", exp_tab[n_seen].imm, dec.imm);
                compare_field("dec.rs1", 32'(exp_tab[n_seen].rs1), 32'(dec.rs1));
                compare_field("dec.rs2", 32'(exp_tab[n_seen].rs2), 32'(dec.rs2));
                compare_field("dec.rd", 32'(exp_tab[n_seen].rd), 32'(dec.rd));
            end
            n_seen++;
        end
    end

    final begin
        $display("packets checked %0d of %0d, errors %0d", n_seen, n_rows, n_err);
    end

endmodule

// File: dv/decode_unit_tb.sv
`timescale 1ns/1ps

module decode_unit_tb import decode_pkg::*; ();

    localparam int wait_limit = 200; // Cycles per wait

    logic     clk;
    logic     reset;
    logic     fetch_req;
    logic     fetch_ack;
    fetch_t   fetch;
    logic     dec_req;
    logic     dec_ack;
    decoded_t dec;

    logic [31:0] instr_tab [0:31];
    decoded_t    exp_tab   [0:31];
    int          n_rows;
    int          n_seen;
    int          n_err;
    integer      seed;

    decode_unit u_dut (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_ack (fetch_ack),
        .fetch     (fetch),
        .dec_req   (dec_req),
        .dec_ack   (dec_ack),
        .dec       (dec)
    );

    decode_checker u_chk (
        .clk       (clk),
        .reset     (reset),
        .fetch_ack (fetch_ack),
        .dec_req   (dec_req),
        .dec       (dec),
        .exp_tab   (exp_tab),
        .n_rows    (n_rows),
        .n_seen    (n_seen),
        .n_err     (n_err)
    );

    always #2 clk = ~clk;

    task automatic add_row(input logic [31:0] instr, input logic [1:0] alu_op,
                           input imm_src_t isrc, input branch_src_t br, input logic mw,
                           input logic [1:0] mux, input logic [1:0] wb, input logic rw,
                           input logic bv, input logic is_imm, input logic ill,
                           input alu_op_t ac, input logic [31:0] imm,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [4:0] rd);
        decoded_t e;
        e                   = '0;
        e.pc                = 32'h1000 + 32'(n_rows * 4);
        e.ctrl.alu_op       = alu_op;
        e.ctrl.imm_src      = isrc;
        e.ctrl.branch_src   = br;
        e.ctrl.mem_write    = mw;
        e.ctrl.alu_mux_src  = mux;
        e.ctrl.wb_src       = wb;
        e.ctrl.reg_write    = rw;
        e.ctrl.branch_valid = bv;
        e.ctrl.is_immediate = is_imm;
        e.ctrl.illegal      = ill;
        e.alu_ctrl          = ac;
        e.imm               = imm;
        e.rs1               = rs1;
        e.rs2               = rs2;
        e.rd                = rd;
        instr_tab[n_rows]   = instr;
        exp_tab[n_rows]     = e;
        n_rows++;
    endtask

    initial begin
        int   p_cnt;
        int   c_cnt;
        int   d;
        logic timed_out;
        clk       = 1'b0;
        reset     = 1'b1;
        fetch_req = 1'b0;
        fetch     = '0;
        dec_ack   = 1'b0;
        seed      = 32'h1e00a25b;
        n_rows    = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 32; i++) begin
            exp_tab[i]   = '0;
            instr_tab[i] = '0;
        end

        // instr, alu_op, imm_src, branch, mw, mux, wb, rw, bv, is_imm, ill
        // then alu, imm, rs1, rs2, rd
        add_row(32'h007302B3, 2'b10, imm_i, br_none, 0, 2'b00, 2'b01, 1, 0, 0, 0,
                alu_add, 32'h7, 6, 7, 5);
        add_row(32'h407302B3, 2'b10, imm_i, br_none, 0, 2'b00, 2'b01, 1, 0, 0, 0,
                alu_sub, 32'h407, 6, 7, 5);
        add_row(32'h407352B3, 2'b10, imm_i, br_none, 0, 2'b00, 2'b01, 1, 0, 0, 0,
                alu_sra, 32'h407, 6, 7, 5);
        add_row(32'h007322B3, 2'b10, imm_i, br_none, 0, 2'b00, 2'b01, 1, 0, 0, 0,
                alu_slt, 32'h7, 6, 7, 5);
        add_row(32'h007372B3, 2'b10, imm_i, br_none, 0, 2'b00, 2'b01, 1, 0, 0, 0,
                alu_and, 32'h7, 6, 7, 5);
        add_row(32'hFFF30293, 2'b10, imm_i, br_none, 0, 2'b01, 2'b01, 1, 0, 1, 0,
                alu_add, 32'hFFFFFFFF, 6, 31, 5);
        add_row(32'h40335293, 2'b10, imm_i, br_none, 0, 2'b01, 2'b01, 1, 0, 1, 0,
                alu_sra, 32'h403, 6, 3, 5);
        add_row(32'hFFC32283, 2'b00, imm_i, br_none, 0, 2'b01, 2'b11, 1, 0, 0, 0,
                alu_add, 32'hFFFFFFFC, 6, 28, 5);
        add_row(32'hFFC31283, 2'b00, imm_i_zext_a, br_none, 0, 2'b01, 2'b11, 1, 0, 0, 0,
                alu_add, 32'hFFC, 6, 28, 5);
        add_row(32'hFFC35283, 2'b00, imm_i_zext_a, br_none, 0, 2'b01, 2'b11, 1, 0, 0, 0,
                alu_add, 32'hFFC, 6, 28, 5);
        add_row(32'hFFC33283, 2'b00, imm_i_zext_b, br_none, 0, 2'b01, 2'b11, 1, 0, 0, 0,
                alu_add, 32'hFFC, 6, 28, 5);
        add_row(32'h00830283, 2'b00, imm_i, br_none, 0, 2'b01, 2'b11, 1, 0, 0, 0,
                alu_add, 32'h8, 6, 8, 5);
        add_row(32'hFE732C23, 2'b00, imm_s, br_none, 1, 2'b01, 2'b00, 0, 0, 0, 0,
                alu_add, 32'hFFFFFFF8, 6, 7, 24);
        add_row(32'hFE7308E3, 2'b01, imm_b, br_eq, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'hFFFFFFF0, 6, 7, 17);
        add_row(32'h00731463, 2'b01, imm_b, br_ne, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'h8, 6, 7, 8);
        add_row(32'hFE7348E3, 2'b01, imm_b, br_lt, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'hFFFFFFF0, 6, 7, 17);
        add_row(32'hFE7358E3, 2'b01, imm_b, br_ge, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'hFFFFFFF0, 6, 7, 17);
        add_row(32'hFE7368E3, 2'b01, imm_b, br_ltu, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'hFFFFFFF0, 6, 7, 17);
        add_row(32'hFE7378E3, 2'b01, imm_b, br_geu, 0, 2'b11, 2'b00, 0, 1, 0, 0,
                alu_sub, 32'hFFFFFFF0, 6, 7, 17);
        add_row(32'hFF9FF0EF, 2'b00, imm_j, br_jump, 0, 2'b11, 2'b00, 1, 0, 0, 0,
                alu_add, 32'hFFFFFFF8, 31, 25, 1);
        add_row(32'h000300E7, 2'b00, imm_j, br_jump, 0, 2'b01, 2'b00, 1, 0, 0, 0,
                alu_add, 32'h00030000, 6, 0, 1);
        add_row(32'h123452B7, 2'b00, imm_u, br_none, 0, 2'b00, 2'b10, 1, 0, 0, 0,
                alu_add, 32'h12345000, 8, 3, 5);
        add_row(32'hFFFFF297, 2'b00, imm_u, br_none, 0, 2'b11, 2'b01, 1, 0, 0, 0,
                alu_add, 32'hFFFFF000, 31, 31, 5);
        add_row(32'h00000073, 2'b01, imm_i, br_none, 0, 2'b00, 2'b00, 0, 0, 0, 1,
                alu_sub, 32'h0, 0, 0, 0);
        add_row(32'h0000000F, 2'b01, imm_i, br_none, 0, 2'b00, 2'b00, 0, 0, 0, 1,
                alu_sub, 32'h0, 0, 0, 0);

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        fork
            begin // Producer
                for (int i = 0; i < n_rows && !timed_out; i++) begin
                    @(posedge clk);
                    fetch.instr <= instr_tab[i];
                    fetch.pc    <= 32'h1000 + 32'(i * 4);
                    fetch_req   <= 1'b1;
                    p_cnt = 0;
                    while (!fetch_ack && p_cnt < wait_limit) begin
                        @(posedge clk);
                        p_cnt++;
                    end
                    if (!fetch_ack) begin
                        $display("producer gave up waiting for fetch_ack on row %0d", i);
                        timed_out = 1'b1;
                        break;
                    end
                    fetch_req <= 1'b0;
                    p_cnt = 0;
                    while (fetch_ack && p_cnt < wait_limit) begin
                        @(posedge clk);
                        p_cnt++;
                    end
                    if (fetch_ack) begin
                        $display("fetch_ack stuck high after row %0d", i);
                        timed_out = 1'b1;
                        break;
                    end
                end
            end
            begin // Consumer with random ack delay
                for (int k = 0; k < n_rows && !timed_out; k++) begin
                    c_cnt = 0;
                    while (!dec_req && c_cnt < wait_limit) begin
                        @(posedge clk);
                        c_cnt++;
                    end
                    if (!dec_req) begin
                        $display("consumer saw no dec_req for packet %0d", k);
                        timed_out = 1'b1;
                        break;
                    end
                    d = $unsigned($random(seed)) % 6;
                    repeat (d) @(posedge clk);
                    dec_ack <= 1'b1;
                    c_cnt = 0;
                    while (dec_req && c_cnt < wait_limit) begin
                        @(posedge clk);
                        c_cnt++;
                    end
                    if (dec_req) begin
                        $display("dec_req never dropped for packet %0d", k);
                        timed_out = 1'b1;
                        break;
                    end
                    dec_ack <= 1'b0;
                    @(posedge clk);
                end
            end
        join

        repeat (5) @(posedge clk); // Let any extra packet show up
        if (!timed_out && n_err == 0 && n_seen == n_rows) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: decode_unit.f
source/decode_pkg.sv
source/fourphase_slot.sv
source/main_decoder.sv
source/alu_decoder.sv
source/decode_combine.sv
source/decode_unit.sv
dv/decode_checker.sv
dv/decode_unit_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = decode_unit_tb
FILELIST  = decode_unit.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
